/* verilog/vision_pkg.sv */
`default_nettype none

package vision_pkg;

    // ####################
    // pixel formats
    // ####################

    // rgb565 as the camera delivers it, red in the top bits
    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } pixel565_t;

    typedef logic [7:0] color8_t; // one widened hdmi channel

    // ####################
    // state encodings
    // ####################

    // byte pairing in the packer
    typedef enum logic [0:0] {
        PK_HIGH = 1'b0, // waiting for high byte
        PK_LOW  = 1'b1  // waiting for low byte
    } pack_state_t;

    // line scan-out
    typedef enum logic [1:0] {
        SCAN_WAIT   = 2'd0, // idle until a line is buffered
        SCAN_ACTIVE = 2'd1, // popping pixels
        SCAN_BLANK  = 2'd2  // horizontal blanking
    } scan_state_t;

endpackage : vision_pkg

`default_nettype wire

/* verilog/cam_pixel_packer.sv */
`timescale 1ns/1ps
`default_nettype none

module cam_pixel_packer
    import vision_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       cam_href,    // line active
    input  logic       cam_byte_en, // one byte per strobe
    input  logic [7:0] cam_data,
    output logic       pix_wr,
    output pixel565_t  pix_data
);

    pack_state_t state;
    logic [7:0]  high_byte;     // first byte of the pair

    logic byte_take;

    assign byte_take = cam_href && cam_byte_en;

    // ####################
    // pairing fsm
    // ####################

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= PK_HIGH;
            pix_wr <= 1'b0;
        end else begin
            pix_wr <= 1'b0;
            if (!cam_href) begin
                state <= PK_HIGH; // lone byte at end of line is dropped
            end else if (cam_byte_en) begin
                case (state)
                    PK_HIGH: begin
                        state <= PK_LOW;
                    end
                    PK_LOW: begin
                        state  <= PK_HIGH;
                        pix_wr <= 1'b1;
                    end
                    default: begin
                        state <= PK_HIGH;
                    end
                endcase
            end
        end
    end

    // ####################
    // pixel payload
    // ####################

    always_ff @(posedge clk) begin
        if (byte_take) begin
            if (state == PK_HIGH) begin
                high_byte <= cam_data;
            end else begin
                pix_data <= {high_byte, cam_data}; // high byte carries red
            end
        end
    end

endmodule : cam_pixel_packer

`default_nettype wire

/* verilog/pixel_line_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_line_fifo
    import vision_pkg::*;
#(
    parameter int FIFO_DEPTH = 32 // power of two
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          pix_wr,
    input  pixel565_t                     pix_data,
    input  logic                          pop,
    output pixel565_t                     rd_data,
    output logic [$clog2(FIFO_DEPTH):0]   fill_level,
    output logic                          buf_overflow
);

    localparam int AW = $clog2(FIFO_DEPTH);

    pixel565_t mem [FIFO_DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;

    logic full;
    logic empty;
    logic do_wr;
    logic do_rd;

    assign full  = (fill_level == FIFO_DEPTH);
    assign empty = (fill_level == '0);
    assign do_wr = pix_wr && !full;     // no room, pixel is lost
    assign do_rd = pop && !empty;

    // ####################
    // pointers and level
    // ####################

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            fill_level   <= '0;
            buf_overflow <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1; // wraps at depth
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   fill_level <= fill_level + 1'b1;
                2'b01:   fill_level <= fill_level - 1'b1;
                default: fill_level <= fill_level;
            endcase
            if (pix_wr && full) begin
                buf_overflow <= 1'b1; // sticky until reset
            end
        end
    end

    // ####################
    // storage
    // ####################

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= pix_data;
        end
    end

    always_ff @(posedge clk) begin
        if (do_rd) begin
            rd_data <= mem[rd_ptr]; // valid the cycle after pop
        end
    end

endmodule : pixel_line_fifo

`default_nettype wire

/* verilog/hdmi_scan_out.sv */
`timescale 1ns/1ps
`default_nettype none

module hdmi_scan_out
    import vision_pkg::*;
#(
    parameter int H_ACTIVE  = 16, // pixels per line
    parameter int H_BLANK   = 8,  // at least HSYNC_LEN
    parameter int HSYNC_LEN = 4,
    parameter int LEVEL_W   = 6   // width of the fifo fill level
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               out_en,     // display side is up
    input  logic [LEVEL_W-1:0] fill_level,
    output logic               pop,
    input  pixel565_t          rd_data,
    output logic               hdmi_hsync,
    output logic               hdmi_de,
    output color8_t            hdmi_r,
    output color8_t            hdmi_g,
    output color8_t            hdmi_b
);

    localparam int MAX_LEN = (H_ACTIVE > H_BLANK) ? H_ACTIVE : H_BLANK;
    localparam int CNT_W   = $clog2(MAX_LEN + 1);

    scan_state_t      state;
    logic [CNT_W-1:0] pos;          // position within active or blank part

    logic line_ready;
    logic scan_active;

    assign line_ready  = out_en && (fill_level >= LEVEL_W'(H_ACTIVE));
    assign scan_active = (state == SCAN_ACTIVE);
    assign pop         = scan_active; // one pop per active cycle

    // ####################
    // line fsm
    // ####################

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SCAN_WAIT;
            pos   <= '0;
        end else begin
            case (state)
                SCAN_WAIT: begin
                    pos <= '0;
                    if (line_ready) begin
                        state <= SCAN_ACTIVE;
                    end
                end
                SCAN_ACTIVE: begin
                    if (pos == CNT_W'(H_ACTIVE - 1)) begin
                        state <= SCAN_BLANK;
                        pos   <= '0;
                    end else begin
                        pos <= pos + 1'b1;
                    end
                end
                SCAN_BLANK: begin
                    if (pos == CNT_W'(H_BLANK - 1)) begin
                        // back to back lines when the next one is already in
                        pos   <= '0;
                        state <= line_ready ? SCAN_ACTIVE : SCAN_WAIT;
                    end else begin
                        pos <= pos + 1'b1;
                    end
                end
                default: begin
                    state <= SCAN_WAIT;
                    pos   <= '0;
                end
            endcase
        end
    end

    // ####################
    // video timing
    // ####################

    // both delayed one cycle to line up with the registered fifo data
    always_ff @(posedge clk) begin
        if (rst) begin
            hdmi_de    <= 1'b0;
            hdmi_hsync <= 1'b0;
        end else begin
            hdmi_de    <= scan_active;
            hdmi_hsync <= (state == SCAN_BLANK) && (pos < CNT_W'(HSYNC_LEN));
        end
    end

    // zero padded widening, black outside de
    assign hdmi_r = hdmi_de ? {rd_data.r, 3'b000} : '0;
    assign hdmi_g = hdmi_de ? {rd_data.g, 2'b00}  : '0;
    assign hdmi_b = hdmi_de ? {rd_data.b, 3'b000} : '0;

endmodule : hdmi_scan_out

`default_nettype wire

/* verilog/cam_display_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cam_display_top
    import vision_pkg::*;
#(
    parameter int H_ACTIVE   = 16,
    parameter int H_BLANK    = 8,
    parameter int HSYNC_LEN  = 4,
    parameter int FIFO_DEPTH = 32  // must hold at least one line
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       cam_href,
    input  logic       cam_byte_en,
    input  logic [7:0] cam_data,
    input  logic       out_en,
    output logic       hdmi_hsync,
    output logic       hdmi_de,
    output color8_t    hdmi_r,
    output color8_t    hdmi_g,
    output color8_t    hdmi_b,
    output logic       buf_overflow
);

    localparam int LEVEL_W = $clog2(FIFO_DEPTH) + 1;

    logic               pix_wr;
    pixel565_t          pix_data;
    logic               pop;
    pixel565_t          rd_data;
    logic [LEVEL_W-1:0] fill_level;

    // camera side
    cam_pixel_packer u_packer (
        .clk        (clk        ),
        .rst        (rst        ),
        .cam_href   (cam_href   ),
        .cam_byte_en(cam_byte_en),
        .cam_data   (cam_data   ),
        .pix_wr     (pix_wr     ),
        .pix_data   (pix_data   )
    );

    pixel_line_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_line_fifo (
        .clk         (clk         ),
        .rst         (rst         ),
        .pix_wr      (pix_wr      ),
        .pix_data    (pix_data    ),
        .pop         (pop         ),
        .rd_data     (rd_data     ),
        .fill_level  (fill_level  ),
        .buf_overflow(buf_overflow)
    );

    // display side
    hdmi_scan_out #(
        .H_ACTIVE (H_ACTIVE ),
        .H_BLANK  (H_BLANK  ),
        .HSYNC_LEN(HSYNC_LEN),
        .LEVEL_W  (LEVEL_W  )
    ) u_scan_out (
        .clk       (clk       ),
        .rst       (rst       ),
        .out_en    (out_en    ),
        .fill_level(fill_level),
        .pop       (pop       ),
        .rd_data   (rd_data   ),
        .hdmi_hsync(hdmi_hsync),
        .hdmi_de   (hdmi_de   ),
        .hdmi_r    (hdmi_r    ),
        .hdmi_g    (hdmi_g    ),
        .hdmi_b    (hdmi_b    )
    );

endmodule : cam_display_top

`default_nettype wire

/* test/cam_display_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module cam_display_chk #(
    parameter int H_ACTIVE = 16,
    parameter int H_BLANK  = 8,
    parameter int LEVEL_W  = 6
) (
    input logic               clk,
    input logic               rst,
    input logic               out_en,
    input logic [LEVEL_W-1:0] fill_level,
    input logic               pop,
    input logic               hdmi_de
);

    int assert_fails = 0;

    // de rises two cycles after the line start decision
    de_needs_line: assert property (@(posedge clk) disable iff (rst)
        $rose(hdmi_de) |-> ($past(out_en, 2) && ($past(fill_level, 2) >= LEVEL_W'(H_ACTIVE))))
    else begin
        assert_fails++;
        $error("hdmi_de rose without a full line buffered");
    end

    // a started line always finds its pixels in the fifo
    pop_not_empty: assert property (@(posedge clk) disable iff (rst)
        pop |-> (fill_level != '0))
    else begin
        assert_fails++;
        $error("pop while the fifo is empty");
    end

    // whole blanking part between two lines
    blank_before_line: assert property (@(posedge clk) disable iff (rst)
        $rose(hdmi_de) |-> !$past(hdmi_de, H_BLANK))
    else begin
        assert_fails++;
        $error("hdmi_de rose before the blanking part was over");
    end

endmodule : cam_display_chk

bind hdmi_scan_out cam_display_chk #(
    .H_ACTIVE(H_ACTIVE),
    .H_BLANK (H_BLANK ),
    .LEVEL_W (LEVEL_W )
) chk (
    .clk(clk), .rst(rst), .out_en(out_en), .fill_level(fill_level),
    .pop(pop), .hdmi_de(hdmi_de)
);

`default_nettype wire

/* test/cam_display_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cam_display_tb
    import vision_pkg::*;
();

    localparam int H_ACTIVE    = 16;
    localparam int H_BLANK     = 8;
    localparam int HSYNC_LEN   = 4;
    localparam int FIFO_DEPTH  = 32;
    localparam int CLK_HALF    = 20;
    localparam int DRV_DLY     = 2;
    localparam int N_LINES     = 6;
    localparam int ODD_BYTES   = 13;                            // ends on a lone byte
    localparam int FILL_BYTES  = 2 * H_ACTIVE - (ODD_BYTES - 1); // tops up to a whole line
    localparam int OVF_PIXELS  = 40;
    localparam int TOTAL_BYTES = N_LINES * 2 * H_ACTIVE + ODD_BYTES + FILL_BYTES
                                 + 2 * OVF_PIXELS;
    localparam int TIMEOUT_CYCLES = TOTAL_BYTES * 5 + 200;

    logic       clk;
    logic       rst;
    logic       cam_href;
    logic       cam_byte_en;
    logic [7:0] cam_data;
    logic       out_en;
    logic       hdmi_hsync;
    logic       hdmi_de;
    color8_t    hdmi_r;
    color8_t    hdmi_g;
    color8_t    hdmi_b;
    logic       buf_overflow;

    logic [31:0] lfsr = 32'd88085;
    pixel565_t   exp_q[$];      // pixels the fifo should still deliver
    logic        exp_ovf = 1'b0;
    logic        prev_de = 1'b0;
    logic        prev_hs = 1'b0;
    int          de_run = 0;
    int          hs_run = 0;
    int          lines_seen = 0;
    int          lines_start = 0;
    int          cycles = 0;

    cam_display_top dut (
        .clk(clk), .rst(rst), .cam_href(cam_href), .cam_byte_en(cam_byte_en),
        .cam_data(cam_data), .out_en(out_en), .hdmi_hsync(hdmi_hsync),
        .hdmi_de(hdmi_de), .hdmi_r(hdmi_r), .hdmi_g(hdmi_g), .hdmi_b(hdmi_b),
        .buf_overflow(buf_overflow)
    );

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    // ####################
    // helpers
    // ####################

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_color(input string name, input color8_t got, input color8_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0d ns: %s got %0h expected %0h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0d ns: %s got %b expected %b",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("Mismatch at %0d ns: %s got %0d expected %0d",
                                $time, name, got, exp));
        end
    endtask

    // 32 bit fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[6:0], lfsr[0]};
        end
    endtask

    task automatic step();
        @(posedge clk);
        #DRV_DLY;
    endtask

    task automatic model_write(input pixel565_t p);
        if (exp_q.size() < FIFO_DEPTH) begin
            exp_q.push_back(p);
        end else begin
            exp_ovf = 1'b1; // no room left, pixel is lost
        end
    endtask

    task automatic send_line(input int nbytes);
        logic [7:0] d;
        logic [7:0] hi;
        logic [7:0] gap;
        int         i;
        hi       = '0;
        cam_href = 1'b1;
        for (i = 0; i < nbytes; i++) begin
            rand_bits(2, gap);
            repeat (gap) step();
            rand_bits(8, d);
            cam_byte_en = 1'b1;
            cam_data    = d;
            step();
            cam_byte_en = 1'b0;
            if (i % 2 == 0) begin
                hi = d;
            end else begin
                model_write({hi, d}); // high byte first
            end
        end
        cam_href = 1'b0;
        rand_bits(2, gap);
        repeat (gap + 1) step();
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            step();
        end
        repeat (H_ACTIVE + H_BLANK + 2) step(); // let the blank part finish
    endtask

    // ####################
    // output monitor
    // ####################

    always @(negedge clk) begin : monitor
        pixel565_t p;
        if (rst) begin
            de_run = 0;
            hs_run = 0;
        end else if (dut.u_scan_out.chk.assert_fails != 0) begin
            abort_run("an assertion in the scan-out checker failed");
        end else begin
            if (hdmi_de) begin
                if (exp_q.size() == 0) begin
                    abort_run("a pixel was displayed with the model queue empty");
                end else begin
                    p = exp_q.pop_front();
                    check_color("hdmi_r", hdmi_r, {p.r, 3'b000});
                    check_color("hdmi_g", hdmi_g, {p.g, 2'b00});
                    check_color("hdmi_b", hdmi_b, {p.b, 3'b000});
                    check_level("buf_overflow", buf_overflow, exp_ovf);
                    de_run++;
                end
            end else begin
                check_color("hdmi_r", hdmi_r, '0);
                check_color("hdmi_g", hdmi_g, '0);
                check_color("hdmi_b", hdmi_b, '0);
            end
            if (prev_de && !hdmi_de) begin
                check_count("de line length", de_run, H_ACTIVE);
                check_level("hdmi_hsync", hdmi_hsync, 1'b1); // sync right after de
                de_run = 0;
                lines_seen++;
            end
            if (hdmi_hsync) begin
                if (!prev_hs) begin
                    check_level("hdmi_de before hsync", prev_de, 1'b1);
                end
                hs_run++;
            end else if (prev_hs) begin
                check_count("hsync length", hs_run, HSYNC_LEN);
                hs_run = 0;
            end
        end
        prev_de = hdmi_de;
        prev_hs = hdmi_hsync;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout, run not finished after %0d cycles", cycles));
        end
    end

    // ####################
    // stimulus
    // ####################

    initial begin
        rst         = 1'b1;
        cam_href    = 1'b0;
        cam_byte_en = 1'b0;
        cam_data    = '0;
        out_en      = 1'b0;
        repeat (2) @(posedge clk);
        #DRV_DLY;
        rst = 1'b0;
        check_level("hdmi_de", hdmi_de, 1'b0);
        check_level("hdmi_hsync", hdmi_hsync, 1'b0);
        check_level("buf_overflow", buf_overflow, 1'b0);
        check_color("hdmi_r", hdmi_r, '0);
        check_color("hdmi_g", hdmi_g, '0);
        check_color("hdmi_b", hdmi_b, '0);
        out_en = 1'b1;
        repeat (N_LINES) send_line(2 * H_ACTIVE);
        wait_drain();
        check_count("lines shown", lines_seen, N_LINES);
        send_line(ODD_BYTES);   // lone last byte must vanish
        send_line(FILL_BYTES);
        wait_drain();
        check_count("lines shown", lines_seen, N_LINES + 1);
        check_level("buf_overflow", buf_overflow, 1'b0);
        // display held off while the camera overruns the buffer
        out_en      = 1'b0;
        lines_start = lines_seen;
        send_line(2 * OVF_PIXELS);
        check_level("buf_overflow", buf_overflow, exp_ovf);
        check_level("hdmi_de", hdmi_de, 1'b0);
        out_en = 1'b1;
        wait_drain();
        repeat (2 * (H_ACTIVE + H_BLANK)) step();
        check_count("lines after overflow", lines_seen - lines_start, 2);
        check_level("buf_overflow", buf_overflow, 1'b1);
        rst = 1'b1;
        repeat (2) step();
        rst = 1'b0;
        check_level("buf_overflow", buf_overflow, 1'b0);
        if (dut.u_scan_out.chk.assert_fails != 0) begin
            abort_run("an assertion in the scan-out checker failed");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule : cam_display_tb

`default_nettype wire

/* cam_display_top.f */
verilog/vision_pkg.sv
verilog/cam_pixel_packer.sv
verilog/pixel_line_fifo.sv
verilog/hdmi_scan_out.sv
verilog/cam_display_top.sv
test/cam_display_chk.sv
test/cam_display_tb.sv

/* run_sim.sh */
#!/bin/sh
# verilator build and run of the cam_display testbench
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cam_display_tb \
    -f cam_display_top.f \
    && ./obj_dir/Vcam_display_tb +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^TEST PASS$" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
